// File: hw/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Build-wide settings of the execute cluster.

// number of instruction slots per bundle, one alu lane each.
`define EX_LANES 4

// width of operands, immediates and results.
`define EX_XLEN 32

`endif

// File: hw/ex_pkg.sv
`default_nettype none

`include "ex_settings.svh"

package ex_pkg;

    // width of a slot index, never below one bit.
    localparam int unsigned EX_SLOT_W = (`EX_LANES > 1) ? $clog2(`EX_LANES) : 1;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_LUI,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_BEQ,
        ALU_BNE,
        ALU_BGE,
        ALU_BLT
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        logic                valid;
        logic [31:0]         inst;
        logic [`EX_XLEN-1:0] rs1_val;
        logic [`EX_XLEN-1:0] rs2_val;
    } ex_slot_t;

    typedef ex_slot_t [`EX_LANES-1:0] ex_bundle_t;

    typedef struct packed {
        logic                valid;
        alu_op_e             op;
        logic                is_signed; // clear only for sltu, bltu and bgeu.
        logic [`EX_XLEN-1:0] a;
        logic [`EX_XLEN-1:0] b;
        logic                is_branch;
    } ex_uop_t;

    typedef struct packed {
        logic                valid;
        logic                is_branch;
        logic                taken;
        logic [`EX_XLEN-1:0] result;
    } ex_lane_res_t;

    typedef struct packed {
        logic [`EX_LANES-1:0]               mask;
        logic [`EX_LANES-1:0][`EX_XLEN-1:0] results;
        logic                               redirect;
        logic [EX_SLOT_W-1:0]               redirect_slot;
    } ex_commit_t;

endpackage

`default_nettype wire

// File: hw/ex_issue.sv
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module ex_issue
    import ex_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          bundle_valid,
    input  ex_bundle_t                    bundle,
    output logic                          uop_valid,
    output ex_uop_t [`EX_LANES-1:0]       uops
);

    ex_uop_t [`EX_LANES-1:0] decoded;
    ex_uop_t [`EX_LANES-1:0] uop_q;
    logic    [`EX_LANES-1:0] vld_q;

    function automatic ex_uop_t decode_slot(input ex_slot_t slot);
        ex_uop_t             uop;
        logic [6:0]          opcode;
        logic [2:0]          funct3;
        logic                alt;
        logic [`EX_XLEN-1:0] imm_i;
        logic [`EX_XLEN-1:0] imm_u;
        logic [`EX_XLEN-1:0] shamt;
        opcode = slot.inst[6:0];
        funct3 = slot.inst[14:12];
        alt    = slot.inst[30]; // funct7 bit 5 selects sub and sra.
        imm_i  = {{20{slot.inst[31]}}, slot.inst[31:20]};
        imm_u  = {slot.inst[31:12], 12'b0};
        shamt  = {27'b0, slot.inst[24:20]};

        uop           = '0;
        uop.op        = ALU_NOP;
        uop.is_signed = 1'b1;
        uop.a         = slot.rs1_val;
        uop.b         = slot.rs2_val;

        case (opcode)
            OPC_OP: begin
                uop.valid = slot.valid;
                case (funct3)
                    3'b000:  uop.op = alt ? ALU_SUB : ALU_ADD;
                    3'b001:  uop.op = ALU_SLL;
                    3'b010:  uop.op = ALU_SLT;
                    3'b011: begin
                        uop.op        = ALU_SLT;
                        uop.is_signed = 1'b0;
                    end
                    3'b100:  uop.op = ALU_XOR;
                    3'b101:  uop.op = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  uop.op = ALU_OR;
                    default: uop.op = ALU_AND;
                endcase
            end
            OPC_OP_IMM: begin
                uop.valid = slot.valid;
                uop.b     = imm_i;
                case (funct3)
                    3'b000:  uop.op = ALU_ADD; // addi has no subtract form.
                    3'b001: begin
                        uop.op = ALU_SLL;
                        uop.b  = shamt;
                    end
                    3'b010:  uop.op = ALU_SLT;
                    3'b011: begin
                        uop.op        = ALU_SLT;
                        uop.is_signed = 1'b0;
                    end
                    3'b100:  uop.op = ALU_XOR;
                    3'b101: begin
                        uop.op = alt ? ALU_SRA : ALU_SRL;
                        uop.b  = shamt;
                    end
                    3'b110:  uop.op = ALU_OR;
                    default: uop.op = ALU_AND;
                endcase
            end
            OPC_LUI: begin
                uop.valid = slot.valid;
                uop.op    = ALU_LUI;
                uop.a     = '0;
                uop.b     = imm_u;
            end
            OPC_BRANCH: begin
                uop.valid     = slot.valid;
                uop.is_branch = 1'b1;
                case (funct3)
                    3'b000: uop.op = ALU_BEQ;
                    3'b001: uop.op = ALU_BNE;
                    3'b100: uop.op = ALU_BLT;
                    3'b101: uop.op = ALU_BGE;
                    3'b110: begin
                        uop.op        = ALU_BLT;
                        uop.is_signed = 1'b0;
                    end
                    3'b111: begin
                        uop.op        = ALU_BGE;
                        uop.is_signed = 1'b0;
                    end
                    default: begin
                        uop.valid     = 1'b0; // funct3 010 and 011 are reserved.
                        uop.is_branch = 1'b0;
                    end
                endcase
            end
            default: ; // unsupported opcodes stay an invalid no-op.
        endcase
        return uop;
    endfunction

    always_comb begin
        for (int i = 0; i < `EX_LANES; i++) begin
            decoded[i] = decode_slot(bundle[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
            vld_q     <= '0;
        end else begin
            uop_valid <= bundle_valid;
            for (int i = 0; i < `EX_LANES; i++) begin
                vld_q[i] <= bundle_valid & decoded[i].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bundle_valid) begin
            uop_q <= decoded;
        end
    end

    always_comb begin
        for (int i = 0; i < `EX_LANES; i++) begin
            uops[i]       = uop_q[i];
            uops[i].valid = vld_q[i]; // payload may be stale, the valid bit is not.
        end
    end

endmodule

`default_nettype wire

// File: hw/ex_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module ex_alu
    import ex_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         uop_valid,
    input  ex_uop_t      uop,
    output logic         lane_valid,
    output ex_lane_res_t res
);

    logic                live;
    logic                valid_q;
    logic                branch_q;
    logic                taken_q;
    logic [`EX_XLEN-1:0] result_q;

    function automatic logic [`EX_XLEN-1:0] arithmetic(
        input alu_op_e             in_op,
        input logic                in_signed,
        input logic [`EX_XLEN-1:0] in_a,
        input logic [`EX_XLEN-1:0] in_b
    );
        logic [4:0] sh;
        sh = in_b[4:0]; // rv32i shifts by the low five bits only.
        case (in_op)
            ALU_LUI: arithmetic = in_b;
            ALU_ADD: arithmetic = in_a + in_b;
            ALU_SUB: arithmetic = in_a - in_b;
            ALU_AND: arithmetic = in_a & in_b;
            ALU_OR:  arithmetic = in_a | in_b;
            ALU_XOR: arithmetic = in_a ^ in_b;
            ALU_SLL: arithmetic = in_a << sh;
            ALU_SRL: arithmetic = in_a >> sh;
            ALU_SRA: arithmetic = $signed(in_a) >>> sh;
            ALU_SLT: begin
                if (in_signed)
                    arithmetic = {31'b0, $signed(in_a) < $signed(in_b)};
                else
                    arithmetic = {31'b0, in_a < in_b};
            end
            default: arithmetic = in_a + in_b; // branches and no-ops fall through to add.
        endcase
    endfunction

    function automatic logic branch_cmp(
        input alu_op_e             in_op,
        input logic                in_signed,
        input logic [`EX_XLEN-1:0] in_a,
        input logic [`EX_XLEN-1:0] in_b
    );
        case (in_op)
            ALU_BEQ: branch_cmp = (in_a == in_b);
            ALU_BNE: branch_cmp = (in_a != in_b);
            ALU_BGE: branch_cmp = in_signed ? ($signed(in_a) >= $signed(in_b)) : (in_a >= in_b);
            ALU_BLT: branch_cmp = in_signed ? ($signed(in_a) < $signed(in_b)) : (in_a < in_b);
            default: branch_cmp = 1'b0;
        endcase
    endfunction

    assign live = uop_valid & uop.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_valid <= 1'b0;
            valid_q    <= 1'b0;
            branch_q   <= 1'b0;
            taken_q    <= 1'b0;
        end else begin
            lane_valid <= uop_valid;
            valid_q    <= live;
            branch_q   <= live & uop.is_branch;
            taken_q    <= live & branch_cmp(uop.op, uop.is_signed, uop.a, uop.b);
        end
    end

    always_ff @(posedge clk) begin
        result_q <= arithmetic(uop.op, uop.is_signed, uop.a, uop.b);
    end

    assign res = '{valid: valid_q, is_branch: branch_q, taken: taken_q, result: result_q};

endmodule

`default_nettype wire

// File: hw/ex_retire.sv
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module ex_retire
    import ex_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          lane_valid,
    input  ex_lane_res_t [`EX_LANES-1:0]  lanes,
    output logic                          commit_valid,
    output ex_commit_t                    commit
);

    logic                               hit;
    logic [EX_SLOT_W-1:0]               slot_d;
    logic [`EX_LANES-1:0]               mask_d;
    logic [`EX_LANES-1:0][`EX_XLEN-1:0] results_d;

    logic                               redirect_q;
    logic [EX_SLOT_W-1:0]               slot_q;
    logic [`EX_LANES-1:0]               mask_q;
    logic [`EX_LANES-1:0][`EX_XLEN-1:0] results_q;

    // Walk the slots in program order. Once a taken branch is seen, every
    // younger slot is squashed and its result word reads zero.
    always_comb begin
        hit       = 1'b0;
        slot_d    = '0;
        mask_d    = '0;
        results_d = '0;
        for (int i = 0; i < `EX_LANES; i++) begin
            if (lane_valid && lanes[i].valid && !hit) begin
                mask_d[i]    = 1'b1;
                results_d[i] = lanes[i].result;
                if (lanes[i].is_branch && lanes[i].taken) begin
                    hit    = 1'b1; // the branch itself still commits.
                    slot_d = EX_SLOT_W'(i);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            redirect_q   <= 1'b0;
            slot_q       <= '0;
            mask_q       <= '0;
        end else begin
            commit_valid <= lane_valid;
            redirect_q   <= hit;
            slot_q       <= slot_d;
            mask_q       <= mask_d;
        end
    end

    always_ff @(posedge clk) begin
        results_q <= results_d;
    end

    assign commit = '{
        mask:          mask_q,
        results:       results_q,
        redirect:      redirect_q,
        redirect_slot: slot_q
    };

endmodule

`default_nettype wire

// File: hw/ex_cluster.sv
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module ex_cluster
    import ex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       bundle_valid,
    input  ex_bundle_t bundle,
    output logic       commit_valid,
    output ex_commit_t commit
);

    logic                          uop_valid;
    ex_uop_t      [`EX_LANES-1:0]  uops;
    logic         [`EX_LANES-1:0]  lane_valid;
    ex_lane_res_t [`EX_LANES-1:0]  lane_res;

    ex_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .bundle_valid (bundle_valid),
        .bundle       (bundle),
        .uop_valid    (uop_valid),
        .uops         (uops)
    );

    for (genvar i = 0; i < `EX_LANES; i++) begin : g_lane
        ex_alu u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .uop_valid  (uop_valid),
            .uop        (uops[i]),
            .lane_valid (lane_valid[i]),
            .res        (lane_res[i])
        );
    end

    ex_retire u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .lane_valid   (lane_valid[0]), // lanes run in lockstep.
        .lanes        (lane_res),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

`default_nettype wire

// File: tests/ex_cluster_props.sv
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module ex_cluster_props
    import ex_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       bundle_valid,
    input ex_bundle_t bundle,
    input logic       commit_valid,
    input ex_commit_t commit
);

    int unsigned          fail_count = 0;
    logic [`EX_LANES-1:0] slot_valid;

    always_comb begin
        for (int i = 0; i < `EX_LANES; i++) begin
            slot_valid[i] = bundle_valid & bundle[i].valid;
        end
    end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !commit_valid && commit.mask == '0 && !commit.redirect)
    else begin
        $error("commit outputs were active while reset was asserted");
        fail_count++;
    end

    mask_in_valid_slots: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> (commit.mask & ~$past(slot_valid, 3)) == '0)
    else begin
        $error("commit mask holds a slot that was not valid three cycles earlier");
        fail_count++;
    end

    // the redirecting branch is the youngest slot that still commits.
    redirect_at_mask_top: assert property (@(posedge clk) disable iff (!rst_n)
        commit.redirect |-> (commit.mask >> commit.redirect_slot) == `EX_LANES'(1))
    else begin
        $error("redirect slot is not the highest slot of the commit mask");
        fail_count++;
    end

    commit_follows_bundle: assert property (@(posedge clk) disable iff (!rst_n)
        bundle_valid |-> ##3 commit_valid)
    else begin
        $error("an accepted bundle did not commit three cycles later");
        fail_count++;
    end

    gap_follows_bundle: assert property (@(posedge clk) disable iff (!rst_n)
        !bundle_valid |-> ##3 !commit_valid)
    else begin
        $error("a cycle without a bundle produced a commit three cycles later");
        fail_count++;
    end

endmodule

bind ex_cluster ex_cluster_props u_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .bundle_valid (bundle_valid),
    .bundle       (bundle),
    .commit_valid (commit_valid),
    .commit       (commit)
);

`default_nettype wire

// File: tests/tb_ex_cluster.sv
`timescale 1ns/1ns
`default_nettype none

`include "ex_settings.svh"

module tb_ex_cluster
    import ex_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_BUNDLES  = 400;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_BUNDLES + 10) * CLK_PERIOD;

    typedef struct packed {
        logic                               cvalid;
        logic [`EX_LANES-1:0]               mask;
        logic [`EX_LANES-1:0]               care; // result words of branches are left open.
        logic [`EX_LANES-1:0][`EX_XLEN-1:0] results;
        logic                               redirect;
        logic [EX_SLOT_W-1:0]               slot;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        bundle_valid;
    ex_bundle_t  bundle;
    logic        commit_valid;
    ex_commit_t  commit;
    logic [31:0] rng;
    int          errors = 0;
    expect_t     exp_q[$];

    ex_cluster u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .bundle_valid (bundle_valid),
        .bundle       (bundle),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    function automatic logic [31:0] next_rand();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h7fff_ffff;
            3'd2: return 32'h8000_0000;
            3'd3: return 32'hffff_ffff;
            3'd4: return 32'd31 + r[7:3]; // shift amounts of 31 and above.
            default: return next_rand();
        endcase
    endfunction

    function automatic ex_slot_t random_slot();
        ex_slot_t    s;
        logic [31:0] r;
        logic [31:0] u;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r = next_rand();
        u = next_rand();
        f3 = r[5:3];
        f7 = (r[6] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        s.valid = (r[9:8] != 2'b00);
        s.rs1_val = pick_operand();
        s.rs2_val = r[10] ? s.rs1_val : pick_operand(); // equal operands make beq taken.
        case (r[2:0])
            3'd0, 3'd1: s.inst = {f7, r[25:21], r[20:16], f3, r[15:11], OPC_OP};
            3'd2, 3'd3: s.inst = {(f3 == 3'd1 || f3 == 3'd5) ? f7 : u[11:5], u[4:0],
                                  r[20:16], f3, r[15:11], OPC_OP_IMM};
            3'd4: s.inst = {u[19:0], r[15:11], OPC_LUI};
            3'd5, 3'd6: s.inst = {u[6:0], r[25:21], r[20:16], f3, u[11:7], OPC_BRANCH};
            default: s.inst = {u[24:0], u[0] ? 7'b0000011 : 7'b1101111};
        endcase
        return s;
    endfunction

    function automatic ex_lane_res_t model_slot(input ex_slot_t s);
        ex_lane_res_t r;
        logic [31:0]  a;
        logic [31:0]  b;
        logic [2:0]   f3;
        logic         is_op;
        a = s.rs1_val;
        f3 = s.inst[14:12];
        is_op = (s.inst[6:0] == OPC_OP);
        b = is_op ? s.rs2_val : {{20{s.inst[31]}}, s.inst[31:20]};
        r = '0;
        if (is_op || s.inst[6:0] == OPC_OP_IMM) begin
            r.valid = s.valid;
            case (f3)
                3'd0: r.result = (is_op && s.inst[30]) ? a - b : a + b;
                3'd1: r.result = a << b[4:0];
                3'd2: r.result = {31'b0, $signed(a) < $signed(b)};
                3'd3: r.result = {31'b0, a < b};
                3'd4: r.result = a ^ b;
                3'd5: begin
                    r.result = a >> b[4:0];
                    if (s.inst[30])
                        r.result = $signed(a) >>> b[4:0];
                end
                3'd6: r.result = a | b;
                default: r.result = a & b;
            endcase
        end else if (s.inst[6:0] == OPC_LUI) begin
            r.valid = s.valid;
            r.result = {s.inst[31:12], 12'b0};
        end else if (s.inst[6:0] == OPC_BRANCH) begin
            r.is_branch = 1'b1;
            r.valid = s.valid && (f3[2:1] != 2'b01);
            b = s.rs2_val;
            case (f3)
                3'd0: r.taken = (a == b);
                3'd1: r.taken = (a != b);
                3'd4: r.taken = ($signed(a) < $signed(b));
                3'd5: r.taken = ($signed(a) >= $signed(b));
                3'd6: r.taken = (a < b);
                default: r.taken = (a >= b);
            endcase
            r.taken = r.taken & r.valid;
        end
        return r;
    endfunction

    function automatic expect_t model_bundle(input logic bv, input ex_bundle_t bnd);
        expect_t      e;
        ex_lane_res_t r;
        logic         hit;
        e = '0;
        e.care = '1;
        e.cvalid = bv;
        hit = 1'b0;
        for (int i = 0; i < `EX_LANES; i++) begin
            r = model_slot(bnd[i]);
            if (bv && r.valid && !hit) begin
                e.mask[i] = 1'b1;
                e.care[i] = !r.is_branch;
                e.results[i] = r.result;
                if (r.taken) begin
                    hit = 1'b1;
                    e.redirect = 1'b1;
                    e.slot = EX_SLOT_W'(i);
                end
            end
        end
        return e;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_commit(input expect_t e);
        check_value("commit_valid", e.cvalid, commit_valid);
        if (e.cvalid) begin
            check_value("commit.mask", e.mask, commit.mask);
            check_value("commit.redirect", e.redirect, commit.redirect);
            check_value("commit.redirect_slot", e.slot, commit.redirect_slot);
            for (int i = 0; i < `EX_LANES; i++) begin
                if (e.care[i])
                    check_value($sformatf("commit.results[%0d]", i), e.results[i],
                                commit.results[i]);
            end
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : stimulus
        logic       bv;
        ex_bundle_t b;
        rng = 32'hdd36;
        rst_n = 1'b1;
        bundle_valid = 1'b0;
        bundle = '0;
        #1 rst_n = 1'b0; // a falling edge lets the asynchronous reset act at once.
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            check_value("commit_valid", 32'd0, commit_valid);
            check_value("commit.mask", 32'd0, commit.mask);
            check_value("commit.redirect", 32'd0, commit.redirect);
        end
        rst_n = 1'b1;
        repeat (3) exp_q.push_back(model_bundle(1'b0, '0));
        for (int n = 0; n < NUM_BUNDLES + 3; n++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            bv = 1'b0;
            b = '0;
            if (n < NUM_BUNDLES) begin
                bv = (next_rand() % 5 != 0);
                for (int i = 0; i < `EX_LANES; i++) begin
                    b[i] = random_slot();
                end
            end
            bundle_valid = bv;
            bundle = b;
            exp_q.push_back(model_bundle(bv, b));
            @(negedge clk);
            compare_commit(exp_q.pop_front()); // commit of the bundle driven three edges ago.
        end
        $display("errors: %0d in testbench checks, %0d in bound properties",
                 errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not reach its end in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: ex_cluster.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_issue.sv
hw/ex_alu.sv
hw/ex_retire.sv
hw/ex_cluster.sv
tests/ex_cluster_props.sv
tests/tb_ex_cluster.sv

// File: Bender.yml
package:
  name: ex_cluster

sources:
  - include_dirs:
      - hw
    files:
      - hw/ex_pkg.sv
      - hw/ex_issue.sv
      - hw/ex_alu.sv
      - hw/ex_retire.sv
      - hw/ex_cluster.sv
      - target: test
        files:
          - tests/ex_cluster_props.sv
          - tests/tb_ex_cluster.sv
